// ==== logic/sparse_params.svh ====
`ifndef SPARSE_PARAMS_SVH
`define SPARSE_PARAMS_SVH

// ======================================================================
// engine sizes
// ======================================================================

// lanes per block
`define BLOCK_DEPTH     4

// signed activation / weight width
`define DATA_WIDTH      8

// processing elements
`define NUM_PE          2

// block index, up to 16 blocks
`define BLK_ADDR_WIDTH  4

// 16 blocks x 4 lanes of 16-bit products
`define PSUM_WIDTH      24

// apb byte address
`define APB_ADDR_WIDTH  10

`endif

// ==== logic/sparse_pkg.sv ====
`default_nettype none

package sparse_pkg;

    // ==================================================================
    // block controller states
    // ==================================================================
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_DATA,
        COMPUTE,
        DONE
    } ctrl_state_t;

    // ==================================================================
    // word offsets inside the control region
    // ==================================================================
    typedef enum logic [2:0] {
        NUM_BLK = 3'd0,
        START   = 3'd1,
        STATUS  = 3'd2,
        PSUM0   = 3'd3,
        PSUM1   = 3'd4
    } reg_offset_t;

endpackage

`default_nettype wire

// ==== logic/dual_port_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_BITS = 4
) (
    input  wire                  clk,
    input  wire                  we,
    input  wire [DEPTH_BITS-1:0] waddr,
    input  wire [WIDTH-1:0]      wdata,
    input  wire                  re,
    input  wire [DEPTH_BITS-1:0] raddr,
    output logic [WIDTH-1:0]     rdata
);

    // global buffer storage
    logic [WIDTH-1:0] mem [0:(1 << DEPTH_BITS) - 1];

    // host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data shows up the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

interface fetch_if #(
    parameter int N_LANES = `BLOCK_DEPTH
);

    // request side, from block controller
    logic                            req;
    logic [`BLK_ADDR_WIDTH-1:0]      blk;

    // fetched block, from distributor
    logic                            rdy;
    logic [N_LANES*`DATA_WIDTH-1:0]  data;
    logic [N_LANES-1:0]              flag;

    modport ctrl    (output req, blk, input rdy);
    modport fetcher (input req, blk, output rdy, data, flag);
    modport sink    (input data, flag);

endinterface

`default_nettype wire

// ==== logic/apb_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module apb_regfile (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0]           paddr,
    input  wire [31:0]                          pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                act_we,
    output logic                                act_flag_we,
    output logic                                wei_we,
    output logic                                wei_flag_we,
    output logic [`BLK_ADDR_WIDTH:0]            wr_addr,
    output logic [31:0]                         wr_data,
    output logic [`BLK_ADDR_WIDTH-1:0]          num_blk,
    output logic                                start,
    input  wire                                 busy,
    input  wire                                 done,
    input  wire [`NUM_PE*`PSUM_WIDTH-1:0]       psum
);
    import sparse_pkg::*;

    logic [2:0]                 region;
    logic [`BLK_ADDR_WIDTH:0]   word;
    reg_offset_t                offs;
    logic                       access;
    logic                       mapped;
    logic                       err;
    logic                       wr_ok;
    logic                       ctl_wr;

    // ==================================================================
    // address decode
    // ==================================================================
    // region in bits 9:7, word in bits 6:2
    assign region = paddr[9:7];
    assign word   = paddr[6:2];
    assign offs   = reg_offset_t'(word[2:0]);
    assign access = psel & penable;

    always_comb begin
        case (region)
            // one word per block
            3'd0, 3'd1: mapped = (word < (1 << `BLK_ADDR_WIDTH));
            // two words per block, whole region used
            3'd2, 3'd3: mapped = 1'b1;
            // control words 0..4 only
            3'd4:       mapped = (word[4:3] == 2'b00) && (offs <= PSUM1);
            default:    mapped = 1'b0;
        endcase
    end

    // buffers are write-only, nothing changes under a running block loop
    assign err     = !mapped || (!pwrite && region < 3'd4) || (pwrite && busy);
    assign pslverr = access & err;
    assign pready  = 1'b1;

    // refused writes go nowhere
    assign wr_ok  = access & pwrite & !err;
    assign ctl_wr = wr_ok & (region == 3'd4);

    // ==================================================================
    // buffer write strobes
    // ==================================================================
    assign act_we      = wr_ok & (region == 3'd0);
    assign act_flag_we = wr_ok & (region == 3'd1);
    assign wei_we      = wr_ok & (region == 3'd2);
    assign wei_flag_we = wr_ok & (region == 3'd3);
    assign wr_addr     = word;
    assign wr_data     = pwdata;

    // ==================================================================
    // control registers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_blk <= '0;
            start   <= 1'b0;
        end else begin
            // single pulse per accepted start write
            start <= ctl_wr && (offs == START) && pwdata[0];
            if (ctl_wr && (offs == NUM_BLK)) begin
                num_blk <= pwdata[`BLK_ADDR_WIDTH-1:0];
            end
        end
    end

    // read mux, psums sign-extended to 32 bits
    always_comb begin
        prdata = '0;
        if (region == 3'd4) begin
            case (offs)
                NUM_BLK: prdata = {{(32-`BLK_ADDR_WIDTH){1'b0}}, num_blk};
                STATUS:  prdata = {30'd0, done, busy};
                PSUM0:   prdata = {{(32-`PSUM_WIDTH){psum[`PSUM_WIDTH-1]}},
                                   psum[`PSUM_WIDTH-1:0]};
                PSUM1:   prdata = {{(32-`PSUM_WIDTH){psum[2*`PSUM_WIDTH-1]}},
                                   psum[2*`PSUM_WIDTH-1:`PSUM_WIDTH]};
                default: prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/act_distributor.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module act_distributor (
    input  wire                                 clk,
    input  wire                                 rst_n,
    fetch_if.fetcher                            fch,
    output logic                                ram_re,
    output logic [`BLK_ADDR_WIDTH-1:0]          ram_raddr,
    input  wire [`BLOCK_DEPTH*`DATA_WIDTH-1:0]  ram_data,
    input  wire [`BLOCK_DEPTH-1:0]              ram_flag
);

    // ram output valid this cycle
    logic rd_pend;

    // word and flag share the block address
    assign ram_re    = fch.req;
    assign ram_raddr = fch.blk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            fch.rdy <= 1'b0;
        end else begin
            rd_pend <= fch.req;
            // drop on a new request, raise once captured
            if (fch.req) begin
                fch.rdy <= 1'b0;
            end else if (rd_pend) begin
                fch.rdy <= 1'b1;
            end
        end
    end

    // hold lanes until next fetch
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            fch.data <= ram_data;
            fch.flag <= ram_flag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wei_distributor.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module wei_distributor (
    input  wire                                 clk,
    input  wire                                 rst_n,
    fetch_if.fetcher                            fch,
    output logic                                ram_re,
    output logic [`BLK_ADDR_WIDTH:0]            ram_raddr,
    input  wire [`BLOCK_DEPTH*`DATA_WIDTH-1:0]  ram_data,
    input  wire [`BLOCK_DEPTH-1:0]              ram_flag
);

    localparam int WORD = `BLOCK_DEPTH * `DATA_WIDTH;

    // beat 1 reads pe1 and captures pe0, beat 2 captures pe1
    logic [1:0]                 beat;
    logic [`BLK_ADDR_WIDTH-1:0] blk_q;

    // pe0 word in the req cycle, pe1 word right after
    assign ram_re    = fch.req | (beat == 2'd1);
    assign ram_raddr = fch.req ? {fch.blk, 1'b0} : {blk_q, 1'b1};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat    <= 2'd0;
            blk_q   <= '0;
            fch.rdy <= 1'b0;
        end else begin
            if (fch.req) begin
                beat    <= 2'd1;
                blk_q   <= fch.blk;
                fch.rdy <= 1'b0;
            end else if (beat == 2'd1) begin
                beat <= 2'd2;
            end else if (beat == 2'd2) begin
                beat    <= 2'd0;
                fch.rdy <= 1'b1;
            end
        end
    end

    // pe0 in the low lanes, pe1 in the high lanes
    always_ff @(posedge clk) begin
        if (beat == 2'd1) begin
            fch.data[WORD-1:0]         <= ram_data;
            fch.flag[`BLOCK_DEPTH-1:0] <= ram_flag;
        end else if (beat == 2'd2) begin
            fch.data[2*WORD-1:WORD]                   <= ram_data;
            fch.flag[2*`BLOCK_DEPTH-1:`BLOCK_DEPTH]   <= ram_flag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/block_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module block_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire [`BLK_ADDR_WIDTH-1:0]   num_blk,
    fetch_if.ctrl                       act_f,
    fetch_if.ctrl                       wei_f,
    output logic                        mac_en,
    output logic                        clear_acc,
    output logic                        busy,
    output logic                        done
);
    import sparse_pkg::*;

    ctrl_state_t                state;
    ctrl_state_t                state_nxt;
    logic [`BLK_ADDR_WIDTH-1:0] blk_cnt;
    logic [`BLK_ADDR_WIDTH-1:0] last_blk;
    logic                       last;

    // zero blocks runs as one
    assign last_blk = (num_blk == '0) ? '0 : num_blk - 1'b1;
    assign last     = (blk_cnt == last_blk);

    // ==================================================================
    // next state
    // ==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    state_nxt = FETCH;
                end
            end
            FETCH:     state_nxt = WAIT_DATA;
            // both distributors must have the block
            WAIT_DATA: begin
                if (act_f.rdy && wei_f.rdy) begin
                    state_nxt = COMPUTE;
                end
            end
            COMPUTE:   state_nxt = last ? DONE : FETCH;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            blk_cnt <= '0;
        end else begin
            state <= state_nxt;
            // wraps to 0 after the last block, ready for the next run
            if (state == COMPUTE) begin
                blk_cnt <= last ? '0 : blk_cnt + 1'b1;
            end
        end
    end

    // ==================================================================
    // outputs
    // ==================================================================
    assign act_f.req = (state == FETCH);
    assign wei_f.req = (state == FETCH);
    assign act_f.blk = blk_cnt;
    assign wei_f.blk = blk_cnt;

    // first block loads the accumulators
    assign mac_en    = (state == COMPUTE);
    assign clear_acc = mac_en && (blk_cnt == '0);
    assign busy      = (state == FETCH) || (state == WAIT_DATA) || (state == COMPUTE);
    assign done      = (state == DONE);

endmodule

`default_nettype wire

// ==== logic/sparse_pe_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module sparse_pe_array (
    input  wire                                 clk,
    input  wire                                 rst_n,
    fetch_if.sink                               act_s,
    fetch_if.sink                               wei_s,
    input  wire                                 mac_en,
    input  wire                                 clear_acc,
    output logic [`NUM_PE*`PSUM_WIDTH-1:0]      psum
);

    genvar p;

    generate
        for (p = 0; p < `NUM_PE; p++) begin : g_pe
            logic signed [`PSUM_WIDTH-1:0] lane_sum;
            logic signed [`PSUM_WIDTH-1:0] acc;

            // only lanes with both flags set contribute
            always_comb begin
                lane_sum = '0;
                for (int l = 0; l < `BLOCK_DEPTH; l++) begin
                    if (act_s.flag[l] && wei_s.flag[p*`BLOCK_DEPTH+l]) begin
                        lane_sum = lane_sum
                            + $signed(act_s.data[l*`DATA_WIDTH +: `DATA_WIDTH])
                            * $signed(wei_s.data[(p*`BLOCK_DEPTH+l)*`DATA_WIDTH +: `DATA_WIDTH]);
                    end
                end
            end

            // load on block 0, else accumulate
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    acc <= '0;
                end else if (mac_en) begin
                    acc <= clear_acc ? lane_sum : acc + lane_sum;
                end
            end

            assign psum[p*`PSUM_WIDTH +: `PSUM_WIDTH] = acc;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/sparse_engine_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sparse_params.svh"

module sparse_engine_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0]   paddr,
    input  wire [31:0]                  pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr
);

    localparam int WORD = `BLOCK_DEPTH * `DATA_WIDTH;

    // host write side
    logic                           act_we;
    logic                           act_flag_we;
    logic                           wei_we;
    logic                           wei_flag_we;
    logic [`BLK_ADDR_WIDTH:0]       wr_addr;
    logic [31:0]                    wr_data;
    logic [`BLK_ADDR_WIDTH-1:0]     num_blk;
    logic                           start;

    // distributor read side
    logic                           act_re;
    logic [`BLK_ADDR_WIDTH-1:0]     act_raddr;
    logic [WORD-1:0]                act_rdata;
    logic [`BLOCK_DEPTH-1:0]        act_rflag;
    logic                           wei_re;
    logic [`BLK_ADDR_WIDTH:0]       wei_raddr;
    logic [WORD-1:0]                wei_rdata;
    logic [`BLOCK_DEPTH-1:0]        wei_rflag;

    // controller and pe array
    logic                           mac_en;
    logic                           clear_acc;
    logic                           busy;
    logic                           done;
    logic [`NUM_PE*`PSUM_WIDTH-1:0] psum;

    fetch_if #(.N_LANES(`BLOCK_DEPTH))         act_f ();
    fetch_if #(.N_LANES(`NUM_PE*`BLOCK_DEPTH)) wei_f ();

    // ==================================================================
    // host interface
    // ==================================================================
    apb_regfile apb_regfile_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .act_we      (act_we),
        .act_flag_we (act_flag_we),
        .wei_we      (wei_we),
        .wei_flag_we (wei_flag_we),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .num_blk     (num_blk),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .psum        (psum)
    );

    // ==================================================================
    // global buffers
    // ==================================================================
    // activations, one word per block
    dual_port_ram #(.WIDTH(WORD), .DEPTH_BITS(`BLK_ADDR_WIDTH)) act_ram_inst (
        .clk   (clk),
        .we    (act_we),
        .waddr (wr_addr[`BLK_ADDR_WIDTH-1:0]),
        .wdata (wr_data),
        .re    (act_re),
        .raddr (act_raddr),
        .rdata (act_rdata)
    );

    dual_port_ram #(.WIDTH(`BLOCK_DEPTH), .DEPTH_BITS(`BLK_ADDR_WIDTH)) act_flag_ram_inst (
        .clk   (clk),
        .we    (act_flag_we),
        .waddr (wr_addr[`BLK_ADDR_WIDTH-1:0]),
        .wdata (wr_data[`BLOCK_DEPTH-1:0]),
        .re    (act_re),
        .raddr (act_raddr),
        .rdata (act_rflag)
    );

    // weights, two words per block
    dual_port_ram #(.WIDTH(WORD), .DEPTH_BITS(`BLK_ADDR_WIDTH+1)) wei_ram_inst (
        .clk   (clk),
        .we    (wei_we),
        .waddr (wr_addr),
        .wdata (wr_data),
        .re    (wei_re),
        .raddr (wei_raddr),
        .rdata (wei_rdata)
    );

    dual_port_ram #(.WIDTH(`BLOCK_DEPTH), .DEPTH_BITS(`BLK_ADDR_WIDTH+1)) wei_flag_ram_inst (
        .clk   (clk),
        .we    (wei_flag_we),
        .waddr (wr_addr),
        .wdata (wr_data[`BLOCK_DEPTH-1:0]),
        .re    (wei_re),
        .raddr (wei_raddr),
        .rdata (wei_rflag)
    );

    // ==================================================================
    // datapath
    // ==================================================================
    act_distributor act_distributor_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .fch       (act_f.fetcher),
        .ram_re    (act_re),
        .ram_raddr (act_raddr),
        .ram_data  (act_rdata),
        .ram_flag  (act_rflag)
    );

    wei_distributor wei_distributor_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .fch       (wei_f.fetcher),
        .ram_re    (wei_re),
        .ram_raddr (wei_raddr),
        .ram_data  (wei_rdata),
        .ram_flag  (wei_rflag)
    );

    block_ctrl block_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .num_blk   (num_blk),
        .act_f     (act_f.ctrl),
        .wei_f     (wei_f.ctrl),
        .mac_en    (mac_en),
        .clear_acc (clear_acc),
        .busy      (busy),
        .done      (done)
    );

    sparse_pe_array sparse_pe_array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_s     (act_f.sink),
        .wei_s     (wei_f.sink),
        .mac_en    (mac_en),
        .clear_acc (clear_acc),
        .psum      (psum)
    );

endmodule

`default_nettype wire

// ==== tests/sparse_engine_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sparse_engine_tb;

    localparam int          CLK_PERIOD = 10;
    localparam int          MAX_WORDS  = 256;
    localparam int          REC_WORDS  = 8;
    localparam logic [31:0] SEED       = 32'h4590f4ef;

    // control region is region 4 at bits 9:7
    localparam logic [9:0] A_NUM_BLK  = 10'h200;
    localparam logic [9:0] A_START    = 10'h204;
    localparam logic [9:0] A_STATUS   = 10'h208;
    localparam logic [9:0] A_PSUM0    = 10'h20c;
    localparam logic [9:0] A_PSUM1    = 10'h210;
    // word 9 whose low bits alias START
    localparam logic [9:0] A_UNMAPPED = 10'h224;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [9:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // records of REC_WORDS words each
    logic [31:0] tdata [0:MAX_WORDS-1];
    int          n_rec;
    int          value_errors;
    int          other_errors;
    bit          ran_before;
    int unsigned wd_ns;

    sparse_engine_top sparse_engine_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // helpers
    // ==================================================================
    task automatic report_mismatch(input string name, input logic [31:0] seen,
                                   input logic [31:0] expected);
        $display("ERROR %s seen 0x%08h expected 0x%08h at %0t", name, seen, expected, $time);
        value_errors++;
    endtask

    // 0..2 idle cycles between accesses
    task automatic idle_gap();
        int n;
        n = $urandom % 3;
        repeat (n) @(negedge clk);
    endtask

    // called on a falling edge, returns on one
    task automatic apb_write(input logic [9:0] addr, input logic [31:0] data,
                             input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // outputs settled mid low phase of the access cycle
        #1;
        if (pready !== 1'b1) begin
            report_mismatch("pready", {31'd0, pready}, 32'h1);
        end
        if (pslverr !== exp_err) begin
            report_mismatch("pslverr", {31'd0, pslverr}, {31'd0, exp_err});
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        idle_gap();
    endtask

    task automatic apb_read(input logic [9:0] addr, output logic [31:0] rdata,
                            input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        if (pready !== 1'b1) begin
            report_mismatch("pready", {31'd0, pready}, 32'h1);
        end
        if (pslverr !== exp_err) begin
            report_mismatch("pslverr", {31'd0, pslverr}, {31'd0, exp_err});
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        idle_gap();
    endtask

    // one block as act word and flags, then the two pe weight words and flags
    task automatic load_block(input int base);
        logic [3:0] blk;
        blk = tdata[base+1][3:0];
        apb_write({3'd0, 1'b0, blk, 2'b00}, tdata[base+2], 1'b0);
        apb_write({3'd1, 1'b0, blk, 2'b00}, tdata[base+3], 1'b0);
        apb_write({3'd2, blk, 1'b0, 2'b00}, tdata[base+4], 1'b0);
        apb_write({3'd3, blk, 1'b0, 2'b00}, tdata[base+5], 1'b0);
        apb_write({3'd2, blk, 1'b1, 2'b00}, tdata[base+6], 1'b0);
        apb_write({3'd3, blk, 1'b1, 2'b00}, tdata[base+7], 1'b0);
    endtask

    task automatic run_and_check(input int base);
        logic [31:0] rd;
        logic [31:0] exp_status;
        int          polls;
        // done from the previous run still visible
        exp_status = ran_before ? 32'h2 : 32'h0;
        apb_read(A_STATUS, rd, 1'b0);
        if (rd !== exp_status) begin
            report_mismatch("status", rd, exp_status);
        end
        apb_write(A_NUM_BLK, tdata[base+1], 1'b0);
        apb_write(A_START, 32'h1, 1'b0);
        apb_read(A_STATUS, rd, 1'b0);
        if (rd[0] !== 1'b1) begin
            report_mismatch("status.busy", {31'd0, rd[0]}, 32'h1);
        end
        // buffer write while busy is refused
        if (tdata[base+4][0]) begin
            apb_write(10'h000, 32'hdeadbeef, 1'b1);
        end
        polls = 0;
        rd    = '0;
        while (rd[1] !== 1'b1 && polls < 200) begin
            apb_read(A_STATUS, rd, 1'b0);
            polls++;
        end
        if (rd[1] !== 1'b1) begin
            $display("run with num_blk %0d never set done", tdata[base+1]);
            other_errors++;
        end
        apb_read(A_PSUM0, rd, 1'b0);
        if (rd !== tdata[base+2]) begin
            report_mismatch("psum0", rd, tdata[base+2]);
        end
        apb_read(A_PSUM1, rd, 1'b0);
        if (rd !== tdata[base+3]) begin
            report_mismatch("psum1", rd, tdata[base+3]);
        end
        ran_before = 1'b1;
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        int          base;
        logic [31:0] rd;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        value_errors = 0;
        other_errors = 0;
        ran_before   = 1'b0;
        n_rec        = 0;
        void'($urandom(SEED));
        $readmemh("tests/sparse_testdata.hex", tdata);
        // records up to the type 0 marker
        while (n_rec * REC_WORDS < MAX_WORDS && tdata[n_rec * REC_WORDS] !== 32'h0) begin
            n_rec++;
        end
        // at most 8 accesses per record plus a full 16-block run
        wd_ns = n_rec * (REC_WORDS * 2 + 16 * 5 + 50) * CLK_PERIOD * 2 + 100 * CLK_PERIOD;

        // two rising edges in reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // reset values
        apb_read(A_STATUS, rd, 1'b0);
        if (rd !== 32'h0) begin
            report_mismatch("status", rd, 32'h0);
        end
        apb_read(A_PSUM0, rd, 1'b0);
        if (rd !== 32'h0) begin
            report_mismatch("psum0", rd, 32'h0);
        end
        apb_read(A_PSUM1, rd, 1'b0);
        if (rd !== 32'h0) begin
            report_mismatch("psum1", rd, 32'h0);
        end

        // refused accesses ahead of all runs
        apb_read(10'h000, rd, 1'b1);
        apb_write(A_UNMAPPED, 32'h1, 1'b1);
        apb_read(A_UNMAPPED, rd, 1'b1);

        if (n_rec == 0) begin
            $display("no records found in tests/sparse_testdata.hex");
            other_errors++;
        end
        for (int r = 0; r < n_rec; r++) begin
            base = r * REC_WORDS;
            case (tdata[base])
                32'h1:   load_block(base);
                32'h2:   run_and_check(base);
                default: begin
                    $display("record %0d has unknown type %0h", r, tdata[base]);
                    other_errors++;
                end
            endcase
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (wd_ns != 0);
        #(wd_ns);
        $display("timeout after %0d ns, run did not finish", wd_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/sparse_testdata.hex ====
// load record  1 blk act_word act_flag wei0_word wei0_flag wei1_word wei1_flag
// run record   2 num_blk psum0 psum1 busy_write 0 0 0  and type 0 ends the list
1 0 04030201 f 01010101 f 0300ff02 f
1 1 02fd05ff f 01fe0303 f 070100fc f
1 2 8014f60a f ff020202 f 80ff0180 f
2 3 000000c6 00003afd 1 0 0 0
2 2 0000001e 0000001b 0 0 0 0
// mixed flags, block 2 has no activation flags
1 0 04030201 5 01010101 7 0300ff02 c
1 1 02fd05ff d 01fe0303 b 070100fc 6
1 2 8014f60a 0 ff020202 f 80ff0180 f
1 3 04fb06f9 f f50af708 6 fbfcfdfe 9
2 4 ffffff9b fffffff7 1 0 0 0
// num_blk 0 runs block 0 only
2 0 00000004 00000000 0 0 0 0
0 0 0 0 0 0 0 0

// ==== vlog.f ====
+incdir+logic
logic/sparse_pkg.sv
logic/dual_port_ram.sv
logic/fetch_if.sv
logic/apb_regfile.sv
logic/act_distributor.sv
logic/wei_distributor.sv
logic/block_ctrl.sv
logic/sparse_pe_array.sv
logic/sparse_engine_top.sv
tests/sparse_engine_tb.sv

// ==== Makefile ====
# Verilator build for the sparse engine testbench

VERILATOR ?= verilator
TOP       ?= sparse_engine_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
